// ==== list.f ====
+incdir+include
source/i3c_pkg.sv
source/i3c_queue.sv
source/i3c_csr.sv
source/i3c_bus_fsm.sv
source/i3c_phy.sv
source/i3c_top.sv
tests/i3c_assert.sv
tests/i3c_tb.sv

// ==== Bender.yml ====
package:
  name: i3c_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/i3c_pkg.sv
      - source/i3c_queue.sv
      - source/i3c_csr.sv
      - source/i3c_bus_fsm.sv
      - source/i3c_phy.sv
      - source/i3c_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/i3c_assert.sv
      - tests/i3c_tb.sv

// ==== tests/i3c_tb.sv ====
// Testbench for the I3C controller core with CPU driver, bus target model and response checker
`timescale 1ns/1ps
`include "i3c_macros.svh"

module i3c_tb
  import i3c_pkg::*;
();

  localparam int unsigned SCL_HALF        = 3;
  localparam logic [6:0]  TARGET_ADDR     = 7'h2A;
  localparam logic [6:0]  OTHER_ADDR      = 7'h15;
  // START, 8 address bits, ACK, 8 data bits, STOP and queue handover
  localparam int unsigned TRANSFER_CYCLES = (1 + 16 + 2 + 16 + 3) * SCL_HALF + 4;
  localparam int unsigned WAIT_LIMIT      = 4 * TRANSFER_CYCLES + 20;
  localparam int unsigned TIMEOUT_CYCLES  = 12 * TRANSFER_CYCLES + 400;

  logic        clk;
  logic        rst_n;
  cpuif_req_t  cpu_req;
  cpuif_rsp_t  cpu_rsp;
  cpuif_req_t  last_req;
  logic        scl_line;
  logic        sda_drv;
  logic        sda_bus;
  logic        sel_od_pp;
  logic        target_pull;
  int          seed;
  int unsigned value_errs;
  int unsigned other_errs;
  int unsigned cycle_cnt;
  int unsigned cur_thld;
  resp_desc_t  exp_q[$];

  // Bus decoder results
  logic        prev_scl;
  logic        prev_sda;
  int unsigned bus_bits;
  logic [7:0]  bus_addr;
  logic [7:0]  bus_data;
  logic        bus_ack;
  logic [31:0] bus_sel;

  // Open drain line, target only pulls low
  assign sda_bus = sda_drv & ~target_pull;

  i3c_top i_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .cpu_req_i  (cpu_req),
    .cpu_rsp_o  (cpu_rsp),
    .i3c_scl_i  (scl_line),
    .i3c_sda_i  (sda_bus),
    .i3c_scl_o  (scl_line),
    .i3c_sda_o  (sda_drv),
    .sel_od_pp_o(sel_od_pp)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic resp_desc_t expect_resp(input cmd_desc_t cmd);
    resp_desc_t r;
    r.tid  = cmd.tid;
    r.nack = (cmd.addr != TARGET_ADDR);
    return r;
  endfunction

  task automatic check_data(input string name, input logic [`I3C_CSR_DW-1:0] got,
                            input logic [`I3C_CSR_DW-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input resp_desc_t got, input resp_desc_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Called 2 ns after a rising edge, returns at the same point one cycle later
  task automatic cpu_access(input logic is_wr, input csr_reg_e sel,
                            input logic [`I3C_CSR_DW-1:0] wdata, output cpuif_rsp_t rsp);
    cpu_req.req     = 1'b1;
    cpu_req.is_wr   = is_wr;
    cpu_req.addr    = sel;
    cpu_req.wr_data = wdata;
    @(posedge clk);
    #2;
    cpu_req = '0;
    rsp     = cpu_rsp;
    if (is_wr ? !rsp.wr_ack : !rsp.rd_ack) begin
      other_errs++;
      $display("CPU access to register %0d was not acknowledged", sel);
    end
  endtask

  task automatic send_cmd(input logic [6:0] addr, input logic exp_err, output cmd_desc_t cmd);
    cpuif_rsp_t rsp;
    cmd.addr = addr;
    cmd.data = 8'($random(seed));
    cmd.tid  = 4'($random(seed));
    cpu_access(1'b1, REG_CMD_PORT, {12'h0, cmd.tid, cmd.data, 1'b0, cmd.addr}, rsp);
    check_bit("cmd_wr_err", rsp.wr_err, exp_err);
    if (!exp_err) exp_q.push_back(expect_resp(cmd));
  endtask

  // Poll status until n responses are queued, checking the trigger on every read
  task automatic wait_resp_count(input int unsigned n);
    cpuif_rsp_t  rsp;
    int unsigned tries;
    int unsigned cnt;
    tries = 0;
    cnt   = 0;
    while ((cnt < n) && (tries < WAIT_LIMIT)) begin
      cpu_access(1'b0, REG_STATUS, '0, rsp);
      cnt = rsp.rd_data[10:8];
      check_bit("status_thld_trig", rsp.rd_data[4], (cur_thld != 0) && (cnt >= cur_thld));
      tries++;
    end
    if (cnt < n) begin
      other_errs++;
      $display("Gave up waiting for %0d queued responses, only %0d arrived", n, cnt);
    end
  endtask

  task automatic check_bus(input cmd_desc_t cmd);
    logic acked;
    acked = (cmd.addr == TARGET_ADDR);
    check_data("bus_addr_byte", 32'(bus_addr), 32'({cmd.addr, 1'b0}));
    check_bit("bus_ack_bit", bus_ack, !acked);
    // Rising SCL edges including the one inside STOP
    check_data("bus_scl_edges", bus_bits, acked ? 8 + 1 + 8 + 1 : 8 + 1 + 1);
    // Push-pull only on the eight data bits after the ACK
    check_data("bus_sel_od_pp", bus_sel, acked ? 32'h0001_FE00 : 32'h0);
    if (acked) check_data("bus_data_byte", 32'(bus_data), 32'(cmd.data));
  endtask

  // Response checker on the CPU port
  always @(posedge clk) last_req <= cpu_req;

  always @(negedge clk) begin : resp_compare
    resp_desc_t got;
    if (rst_n && last_req.req && !last_req.is_wr && (last_req.addr == REG_RESP_PORT) &&
        cpu_rsp.rd_ack && !cpu_rsp.rd_err) begin
      got.tid  = cpu_rsp.rd_data[3:0];
      got.nack = cpu_rsp.rd_data[8];
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("A response was read back with no command outstanding");
      end else begin
        check_resp("resp_desc", got, exp_q.pop_front());
      end
    end
  end

  // Bus decoder and target, sampled mid cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (scl_line && !prev_scl) begin
        if (bus_bits < 8) bus_addr = {bus_addr[6:0], sda_bus};
        else if (bus_bits == 8) bus_ack = sda_bus;
        else if (bus_bits < 17) bus_data = {bus_data[6:0], sda_bus};
        if (bus_bits < 32) bus_sel[bus_bits] = sel_od_pp;
        bus_bits++;
      end else if (!scl_line && prev_scl) begin
        // ACK held low for the whole ninth bit
        if ((bus_bits == 8) && (bus_addr[7:1] == TARGET_ADDR)) target_pull = 1'b1;
        else if (bus_bits == 9) target_pull = 1'b0;
      end else if (scl_line && prev_scl && prev_sda && !sda_bus) begin
        bus_bits = 0;
        bus_addr = '0;
        bus_data = '0;
        bus_ack  = 1'b1;
        bus_sel  = '0;
      end
    end
    prev_scl = scl_line;
    prev_sda = sda_bus;
  end

  initial begin : main_seq
    cpuif_rsp_t  rsp;
    cmd_desc_t   cmd;
    int unsigned assert_errs;
    clk         = 1'b0;
    rst_n       = 1'b0;
    cpu_req     = '0;
    target_pull = 1'b0;
    prev_scl    = 1'b1;
    prev_sda    = 1'b1;
    bus_bits    = 0;
    seed        = 99;
    value_errs  = 0;
    other_errs  = 0;
    cycle_cnt   = 0;
    cur_thld    = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Reset values, status has cmd empty, resp empty and idle
    check_bit("rd_ack", cpu_rsp.rd_ack, 1'b0);
    check_bit("wr_ack", cpu_rsp.wr_ack, 1'b0);
    check_bit("scl_o", scl_line, 1'b1);
    check_bit("sda_o", sda_drv, 1'b1);
    check_bit("sel_od_pp_o", sel_od_pp, 1'b0);
    cpu_access(1'b0, REG_STATUS, '0, rsp);
    check_data("status_reset", rsp.rd_data, 32'h0000_0025);

    // Register access
    cpu_access(1'b1, REG_CTRL, 32'h1, rsp);
    check_bit("ctrl_wr_err", rsp.wr_err, 1'b0);
    cpu_access(1'b0, REG_CTRL, '0, rsp);
    check_data("ctrl", rsp.rd_data, 32'h1);
    cpu_access(1'b1, REG_CTRL, 32'h0, rsp);
    cpu_access(1'b1, REG_TIMING, SCL_HALF, rsp);
    cpu_access(1'b0, REG_TIMING, '0, rsp);
    check_data("timing", rsp.rd_data, SCL_HALF);
    cpu_access(1'b1, REG_THLD, 32'h3, rsp);
    cpu_access(1'b0, REG_THLD, '0, rsp);
    check_data("thld", rsp.rd_data, 32'h3);
    cpu_access(1'b1, REG_THLD, 32'h0, rsp);
    cpu_access(1'b1, REG_STATUS, 32'hFFFF, rsp);
    check_bit("status_wr_err", rsp.wr_err, 1'b1);
    cpu_access(1'b0, REG_CMD_PORT, '0, rsp);
    check_bit("cmd_port_rd_err", rsp.rd_err, 1'b1);

    // Acknowledged transfer, then a NACK transfer
    cpu_access(1'b1, REG_CTRL, 32'h1, rsp);
    send_cmd(TARGET_ADDR, 1'b0, cmd);
    wait_resp_count(1);
    check_bus(cmd);
    cpu_access(1'b0, REG_RESP_PORT, '0, rsp);
    send_cmd(OTHER_ADDR, 1'b0, cmd);
    wait_resp_count(1);
    check_bus(cmd);
    cpu_access(1'b0, REG_RESP_PORT, '0, rsp);

    // Back-pressure with the bus disabled
    cpu_access(1'b1, REG_CTRL, 32'h0, rsp);
    for (int i = 0; i < `I3C_CMD_DEPTH; i++) begin
      send_cmd(TARGET_ADDR, 1'b0, cmd);
    end
    send_cmd(TARGET_ADDR, 1'b1, cmd);
    cpu_access(1'b0, REG_STATUS, '0, rsp);
    check_bit("status_cmd_full", rsp.rd_data[1], 1'b1);
    cpu_access(1'b0, REG_RESP_PORT, '0, rsp);
    check_bit("resp_rd_err", rsp.rd_err, 1'b1);
    check_data("resp_underflow_data", rsp.rd_data, '0);
    cpu_access(1'b1, REG_THLD, 32'h2, rsp);
    cur_thld = 2;
    cpu_access(1'b1, REG_CTRL, 32'h1, rsp);
    wait_resp_count(2);
    wait_resp_count(`I3C_RESP_DEPTH);
    cpu_access(1'b0, REG_STATUS, '0, rsp);
    check_bit("status_resp_full", rsp.rd_data[3], 1'b1);
    repeat (`I3C_RESP_DEPTH) cpu_access(1'b0, REG_RESP_PORT, '0, rsp);
    cpu_access(1'b0, REG_STATUS, '0, rsp);
    check_data("status_end", rsp.rd_data, 32'h0000_0025);

    repeat (2) @(posedge clk);
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d expected responses were never read back", exp_q.size());
    end
    assert_errs = i_dut.xcsr.i_csr_assert.fail_cnt;
    $display("Error counts: %0d value mismatches, %0d other errors, %0d assertion failures",
             value_errs, other_errs, assert_errs);
    if ((value_errs + other_errs + assert_errs) == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/i3c_assert.sv ====
// CPU port and command queue protocol assertions for the CSR block, bound into i3c_csr
`timescale 1ns/1ps

module i3c_assert
  import i3c_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input cpuif_req_t  cpu_req_i,
  input cpuif_rsp_t  cpu_rsp_i,
  input logic        cmd_wvalid_i,
  input queue_stat_t cmd_stat_i
);

  // Failed assertion count for the testbench summary
  int unsigned fail_cnt = 0;

  // Every request gets the matching ack on the next cycle
  req_ack_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cpu_req_i.req |=> ($past(cpu_req_i.is_wr) ? cpu_rsp_i.wr_ack : cpu_rsp_i.rd_ack))
  else begin
    fail_cnt++;
    $error("CPU request not acknowledged on the next cycle");
  end

  ack_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(cpu_rsp_i.rd_ack && cpu_rsp_i.wr_ack))
  else begin
    fail_cnt++;
    $error("rd_ack and wr_ack high together");
  end

  // A write to a full command queue never raises its fill count
  no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cmd_wvalid_i && cmd_stat_i.full) |=> (cmd_stat_i.count <= $past(cmd_stat_i.count)))
  else begin
    fail_cnt++;
    $error("Command queue accepted a push while full");
  end

endmodule

bind i3c_csr i3c_assert i_csr_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .cpu_req_i   (cpu_req_i),
  .cpu_rsp_i   (cpu_rsp_o),
  .cmd_wvalid_i(cmd_wvalid_o),
  .cmd_stat_i  (cmd_stat_i)
);

// ==== source/i3c_top.sv ====
// Top level connecting CSR block, command and response queues, bus engine and PHY
`timescale 1ns/1ps
`include "i3c_macros.svh"

module i3c_top
  import i3c_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  cpuif_req_t cpu_req_i,
  output cpuif_rsp_t cpu_rsp_o,
  input  logic       i3c_scl_i,
  input  logic       i3c_sda_i,
  output logic       i3c_scl_o,
  output logic       i3c_sda_o,
  output logic       sel_od_pp_o
);

  // Command queue
  logic        cmd_wvalid;
  logic        cmd_wready;
  cmd_desc_t   cmd_wdata;
  logic        cmd_rvalid;
  logic        cmd_rready;
  cmd_desc_t   cmd_rdata;
  queue_stat_t cmd_stat;

  // Response queue
  logic                   resp_wvalid;
  logic                   resp_wready;
  resp_desc_t             resp_wdata;
  logic                   resp_rvalid;
  logic                   resp_rready;
  resp_desc_t             resp_rdata;
  queue_stat_t            resp_stat;
  logic [`I3C_THLD_W-1:0] resp_thld;

  bus_cfg_t bus_cfg;
  logic     bus_idle;

  logic ctrl2phy_scl;
  logic ctrl2phy_sda;
  logic ctrl_sel_od_pp;
  logic phy2ctrl_sda;

  i3c_csr xcsr (
    .clk_i,
    .rst_n_i,
    .cpu_req_i,
    .cpu_rsp_o,
    .cmd_wvalid_o (cmd_wvalid),
    .cmd_wready_i (cmd_wready),
    .cmd_wdata_o  (cmd_wdata),
    .cmd_stat_i   (cmd_stat),
    .resp_rready_o(resp_rready),
    .resp_rvalid_i(resp_rvalid),
    .resp_rdata_i (resp_rdata),
    .resp_stat_i  (resp_stat),
    .resp_thld_o  (resp_thld),
    .bus_cfg_o    (bus_cfg),
    .bus_idle_i   (bus_idle)
  );

  // No ready threshold on the command side
  i3c_queue #(
    .Depth    (`I3C_CMD_DEPTH),
    .DataWidth($bits(cmd_desc_t))
  ) xcmd_queue (
    .clk_i,
    .rst_n_i,
    .wvalid_i(cmd_wvalid),
    .wready_o(cmd_wready),
    .wdata_i (cmd_wdata),
    .rvalid_o(cmd_rvalid),
    .rready_i(cmd_rready),
    .rdata_o (cmd_rdata),
    .thld_i  ('0),
    .stat_o  (cmd_stat)
  );

  i3c_queue #(
    .Depth    (`I3C_RESP_DEPTH),
    .DataWidth($bits(resp_desc_t))
  ) xresp_queue (
    .clk_i,
    .rst_n_i,
    .wvalid_i(resp_wvalid),
    .wready_o(resp_wready),
    .wdata_i (resp_wdata),
    .rvalid_o(resp_rvalid),
    .rready_i(resp_rready),
    .rdata_o (resp_rdata),
    .thld_i  (resp_thld),
    .stat_o  (resp_stat)
  );

  i3c_bus_fsm xbus_fsm (
    .clk_i,
    .rst_n_i,
    .bus_cfg_i    (bus_cfg),
    .cmd_rvalid_i (cmd_rvalid),
    .cmd_rready_o (cmd_rready),
    .cmd_rdata_i  (cmd_rdata),
    .resp_wvalid_o(resp_wvalid),
    .resp_wready_i(resp_wready),
    .resp_wdata_o (resp_wdata),
    .sda_i        (phy2ctrl_sda),
    .scl_o        (ctrl2phy_scl),
    .sda_o        (ctrl2phy_sda),
    .sel_od_pp_o  (ctrl_sel_od_pp),
    .idle_o       (bus_idle)
  );

  i3c_phy xphy (
    .clk_i,
    .rst_n_i,
    .scl_i           (i3c_scl_i),
    .sda_i           (i3c_sda_i),
    .ctrl_scl_i      (ctrl2phy_scl),
    .ctrl_sda_i      (ctrl2phy_sda),
    .ctrl_sel_od_pp_i(ctrl_sel_od_pp),
    .scl_o           (i3c_scl_o),
    .sda_o           (i3c_sda_o),
    .sel_od_pp_o     (sel_od_pp_o),
    .ctrl_sda_o      (phy2ctrl_sda)
  );

endmodule

// ==== source/i3c_phy.sv ====
// Bus input synchronizers and aligned SCL, SDA and driver select output registers
`timescale 1ns/1ps

module i3c_phy
  import i3c_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  input  logic ctrl_scl_i,
  input  logic ctrl_sda_i,
  input  logic ctrl_sel_od_pp_i,
  output logic scl_o,
  output logic sda_o,
  output logic sel_od_pp_o,
  output logic ctrl_sda_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Idle bus levels, open drain
      scl_sync_q  <= 2'b11;
      sda_sync_q  <= 2'b11;
      scl_o       <= 1'b1;
      sda_o       <= 1'b1;
      sel_od_pp_o <= 1'b0;
    end else begin
      scl_sync_q  <= {scl_sync_q[0], scl_i};
      sda_sync_q  <= {sda_sync_q[0], sda_i};
      scl_o       <= ctrl_scl_i;
      sda_o       <= ctrl_sda_i;
      sel_od_pp_o <= ctrl_sel_od_pp_i;
    end
  end

  assign ctrl_sda_o = sda_sync_q[1];

endmodule

// ==== source/i3c_bus_fsm.sv ====
// Bus engine FSM generating START, address, ACK, data byte and STOP for private writes
`timescale 1ns/1ps

module i3c_bus_fsm
  import i3c_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  bus_cfg_t   bus_cfg_i,
  input  logic       cmd_rvalid_i,
  output logic       cmd_rready_o,
  input  cmd_desc_t  cmd_rdata_i,
  output logic       resp_wvalid_o,
  input  logic       resp_wready_i,
  output resp_desc_t resp_wdata_o,
  input  logic       sda_i,
  output logic       scl_o,
  output logic       sda_o,
  output logic       sel_od_pp_o,
  output logic       idle_o
);

  bus_state_e state_q;
  scl_half_t  hcnt_q;
  logic [2:0] bcnt_q;
  logic       hi_q;
  logic       nack_q;
  logic [7:0] shift_q;
  logic [7:0] data_q;
  logic [3:0] tid_q;
  logic       cmd_pop;
  logic       phase_end;
  logic       bit_end;
  logic       last_bit;

  assign cmd_rready_o = (state_q == IDLE) && bus_cfg_i.en;
  assign cmd_pop      = cmd_rready_o && cmd_rvalid_i;

  // A zero half period behaves as one cycle
  assign phase_end = (bus_cfg_i.scl_half == '0) ||
                     (hcnt_q >= bus_cfg_i.scl_half - scl_half_t'(1));
  // End of the SCL high half closes a bit
  assign bit_end  = phase_end && hi_q;
  assign last_bit = (bcnt_q == 3'd7);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      hcnt_q  <= '0;
      bcnt_q  <= '0;
      hi_q    <= 1'b0;
      nack_q  <= 1'b0;
    end else begin
      hcnt_q <= phase_end ? '0 : hcnt_q + 1'b1;
      case (state_q)
        IDLE: begin
          hcnt_q <= '0;
          if (cmd_pop) begin
            state_q <= START;
            bcnt_q  <= '0;
            hi_q    <= 1'b0;
            nack_q  <= 1'b0;
          end
        end
        START: begin
          if (phase_end) state_q <= ADDR;
        end
        ADDR, DATA: begin
          if (phase_end) hi_q <= !hi_q;
          if (bit_end) begin
            bcnt_q <= last_bit ? 3'd0 : bcnt_q + 1'b1;
            if (last_bit) state_q <= (state_q == ADDR) ? ACK : STOP;
          end
        end
        ACK: begin
          if (phase_end) hi_q <= !hi_q;
          // Target pulls SDA low to acknowledge
          if (bit_end) begin
            nack_q  <= sda_i;
            state_q <= sda_i ? STOP : DATA;
          end
        end
        STOP: begin
          // Sub phases: SCL low, SCL high with SDA low, SDA released
          if (phase_end) begin
            if (bcnt_q == 3'd2) begin
              bcnt_q  <= '0;
              state_q <= RESP;
            end else begin
              bcnt_q <= bcnt_q + 1'b1;
            end
          end
        end
        RESP: begin
          hcnt_q <= '0;
          if (resp_wready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Shift register MSB goes out first
  always_ff @(posedge clk_i) begin
    if (cmd_pop) begin
      shift_q <= {cmd_rdata_i.addr, 1'b0};
      data_q  <= cmd_rdata_i.data;
      tid_q   <= cmd_rdata_i.tid;
    end else if ((state_q == ACK) && bit_end) begin
      shift_q <= data_q;
    end else if (((state_q == ADDR) || (state_q == DATA)) && bit_end) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_comb begin
    scl_o       = 1'b1;
    sda_o       = 1'b1;
    sel_od_pp_o = 1'b0;
    case (state_q)
      START: sda_o = 1'b0;
      ADDR: begin
        scl_o = hi_q;
        sda_o = shift_q[7];
      end
      ACK: scl_o = hi_q;
      DATA: begin
        scl_o       = hi_q;
        sda_o       = shift_q[7];
        sel_od_pp_o = 1'b1;
      end
      STOP: begin
        scl_o = (bcnt_q != 3'd0);
        sda_o = (bcnt_q == 3'd2);
      end
      default: begin
        scl_o = 1'b1;
        sda_o = 1'b1;
      end
    endcase
  end

  assign resp_wvalid_o     = (state_q == RESP);
  assign resp_wdata_o.tid  = tid_q;
  assign resp_wdata_o.nack = nack_q;
  assign idle_o            = (state_q == IDLE);

endmodule

// ==== source/i3c_csr.sv ====
// CSR block with CPU decode, configuration registers, status word and queue port access
`timescale 1ns/1ps
`include "i3c_macros.svh"

module i3c_csr
  import i3c_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  cpuif_req_t             cpu_req_i,
  output cpuif_rsp_t             cpu_rsp_o,
  output logic                   cmd_wvalid_o,
  input  logic                   cmd_wready_i,
  output cmd_desc_t              cmd_wdata_o,
  input  queue_stat_t            cmd_stat_i,
  output logic                   resp_rready_o,
  input  logic                   resp_rvalid_i,
  input  resp_desc_t             resp_rdata_i,
  input  queue_stat_t            resp_stat_i,
  output logic [`I3C_THLD_W-1:0] resp_thld_o,
  output bus_cfg_t               bus_cfg_o,
  input  logic                   bus_idle_i
);

  csr_reg_e               reg_sel;
  logic                   wr_req;
  logic                   rd_req;
  logic                   bus_en_q;
  scl_half_t              scl_half_q;
  logic [`I3C_THLD_W-1:0] resp_thld_q;
  logic [`I3C_CSR_DW-1:0] status_word;
  cpuif_rsp_t             rsp_d;
  cpuif_rsp_t             rsp_q;

  assign reg_sel = csr_reg_e'(cpu_req_i.addr);
  assign wr_req  = cpu_req_i.req && cpu_req_i.is_wr;
  assign rd_req  = cpu_req_i.req && !cpu_req_i.is_wr;

  // Command word fields as software packs them
  assign cmd_wvalid_o     = wr_req && (reg_sel == REG_CMD_PORT);
  assign cmd_wdata_o.addr = cpu_req_i.wr_data[6:0];
  assign cmd_wdata_o.data = cpu_req_i.wr_data[15:8];
  assign cmd_wdata_o.tid  = cpu_req_i.wr_data[19:16];

  // Pop on the request cycle, data is captured into the response register
  assign resp_rready_o = rd_req && (reg_sel == REG_RESP_PORT);

  always_comb begin
    status_word       = '0;
    status_word[0]    = cmd_stat_i.empty;
    status_word[1]    = cmd_stat_i.full;
    status_word[2]    = resp_stat_i.empty;
    status_word[3]    = resp_stat_i.full;
    status_word[4]    = resp_stat_i.thld_trig;
    status_word[5]    = bus_idle_i;
    status_word[10:8] = resp_stat_i.count;
  end

  always_comb begin
    rsp_d        = '0;
    rsp_d.wr_ack = wr_req;
    rsp_d.rd_ack = rd_req;
    if (wr_req) begin
      case (reg_sel)
        REG_CTRL, REG_TIMING, REG_THLD: rsp_d.wr_err = 1'b0;
        // Overflow drops the word
        REG_CMD_PORT: rsp_d.wr_err = !cmd_wready_i;
        default: rsp_d.wr_err = 1'b1;
      endcase
    end
    if (rd_req) begin
      case (reg_sel)
        REG_CTRL:   rsp_d.rd_data = `I3C_CSR_DW'(bus_en_q);
        REG_TIMING: rsp_d.rd_data = `I3C_CSR_DW'(scl_half_q);
        REG_THLD:   rsp_d.rd_data = `I3C_CSR_DW'(resp_thld_q);
        REG_STATUS: rsp_d.rd_data = status_word;
        REG_RESP_PORT: begin
          // Underflow returns zero data
          if (resp_rvalid_i) begin
            rsp_d.rd_data[3:0] = resp_rdata_i.tid;
            rsp_d.rd_data[8]   = resp_rdata_i.nack;
          end else begin
            rsp_d.rd_err = 1'b1;
          end
        end
        default: rsp_d.rd_err = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bus_en_q    <= 1'b0;
      scl_half_q  <= scl_half_t'(`I3C_SCL_HALF_RST);
      resp_thld_q <= '0;
      rsp_q       <= '0;
    end else begin
      rsp_q <= rsp_d;
      if (wr_req) begin
        case (reg_sel)
          REG_CTRL:   bus_en_q <= cpu_req_i.wr_data[0];
          REG_TIMING: scl_half_q <= cpu_req_i.wr_data[`I3C_TIMING_W-1:0];
          REG_THLD:   resp_thld_q <= cpu_req_i.wr_data[`I3C_THLD_W-1:0];
          default:    bus_en_q <= bus_en_q;
        endcase
      end
    end
  end

  assign cpu_rsp_o          = rsp_q;
  assign resp_thld_o        = resp_thld_q;
  assign bus_cfg_o.en       = bus_en_q;
  assign bus_cfg_o.scl_half = scl_half_q;

endmodule

// ==== source/i3c_queue.sv ====
// Synchronous valid/ready FIFO with full, empty and ready threshold status
`timescale 1ns/1ps
`include "i3c_macros.svh"

module i3c_queue
  import i3c_pkg::*;
#(
  parameter int unsigned Depth     = `I3C_CMD_DEPTH,
  parameter int unsigned DataWidth = $bits(cmd_desc_t)
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  logic [DataWidth-1:0]   wdata_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output logic [DataWidth-1:0]   rdata_o,
  input  logic [`I3C_THLD_W-1:0] thld_i,
  output queue_stat_t            stat_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [`I3C_THLD_W-1:0] cnt_t;
  typedef logic [PtrW-1:0] ptr_t;

  logic [DataWidth-1:0] mem_q [Depth];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic full;
  logic empty;
  logic push;
  logic pop;

  // Wrap at Depth so non power of two depths work too
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = (count_q == cnt_t'(Depth));
  assign empty    = (count_q == '0);
  assign wready_o = !full;
  assign rvalid_o = !empty;
  assign push     = wvalid_i && !full;
  assign pop      = rready_i && !empty;
  assign rdata_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wdata_i;
  end

  // Zero threshold disables the trigger
  assign stat_o.full      = full;
  assign stat_o.empty     = empty;
  assign stat_o.thld_trig = (thld_i != '0) && (count_q >= thld_i);
  assign stat_o.count     = count_q;

endmodule

// ==== source/i3c_pkg.sv ====
// CPU port, descriptor, queue status and bus configuration types, register and state enums
`include "i3c_macros.svh"

package i3c_pkg;

  typedef logic [`I3C_TIMING_W-1:0] scl_half_t;

  // CPU request, single cycle strobe
  typedef struct packed {
    logic                   req;
    logic                   is_wr;
    logic [`I3C_CSR_AW-1:0] addr;
    logic [`I3C_CSR_DW-1:0] wr_data;
  } cpuif_req_t;

  // CPU response, acks pulse one cycle after req
  typedef struct packed {
    logic                   rd_ack;
    logic                   rd_err;
    logic                   wr_ack;
    logic                   wr_err;
    logic [`I3C_CSR_DW-1:0] rd_data;
  } cpuif_rsp_t;

  // Private write command
  typedef struct packed {
    logic [3:0] tid;
    logic [7:0] data;
    logic [6:0] addr;
  } cmd_desc_t;

  // Transfer result
  typedef struct packed {
    logic [3:0] tid;
    logic       nack;
  } resp_desc_t;

  typedef struct packed {
    logic                   full;
    logic                   empty;
    logic                   thld_trig;
    logic [`I3C_THLD_W-1:0] count;
  } queue_stat_t;

  typedef struct packed {
    logic      en;
    scl_half_t scl_half;
  } bus_cfg_t;

  // CSR register map
  typedef enum logic [`I3C_CSR_AW-1:0] {
    REG_CTRL      = 'd0,
    REG_TIMING    = 'd1,
    REG_THLD      = 'd2,
    REG_STATUS    = 'd3,
    REG_CMD_PORT  = 'd4,
    REG_RESP_PORT = 'd5
  } csr_reg_e;

  typedef enum logic [2:0] {
    IDLE,
    START,
    ADDR,
    ACK,
    DATA,
    STOP,
    RESP
  } bus_state_e;

endpackage

// ==== include/i3c_macros.svh ====
// Queue depths, CSR port widths and SCL timing constants for the I3C controller core
`ifndef I3C_MACROS_SVH
`define I3C_MACROS_SVH

// CSR port geometry
`define I3C_CSR_AW 4
`define I3C_CSR_DW 32

// Queue depths in descriptors
`define I3C_CMD_DEPTH 4
`define I3C_RESP_DEPTH 4

// Threshold and fill count width, wide enough to hold a full depth
`define I3C_THLD_W 3

// SCL half period counter
`define I3C_TIMING_W 8

// Half period in clock cycles after reset
`define I3C_SCL_HALF_RST 4

`endif
